// ==== src/decode_macros.svh ====
// Sizing and flag group codes for the decode stage
// Only 32 is supported for the PC, immediate and displacement widths
// Flag group codes are shared with the execute side

`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// PC width
`define DEC_IADDRW 32

// Immediate and displacement after sign extension
`define DEC_IMMW 32
`define DEC_DISPW 32

// Microcode ROM entries
`define DEC_UCODE_DEPTH 8

// Flag groups for flag_0 (written) and flag_1 (read)
`define DEC_FLG_NONE  3'd0
`define DEC_FLG_ARITH 3'd1
`define DEC_FLG_DIR   3'd2
`define DEC_FLG_ALL   3'd7

`endif

// ==== src/decode_pkg.sv ====
// Types for the stage-0 bundle and the micro-op sent to execute
// Enum encodings are seen by the execute side and must stay stable
// Multi-byte fields keep their first byte in the low bits
`default_nettype none
`include "decode_macros.svh"

package decode_pkg;

   typedef logic [`DEC_IADDRW-1:0] pc_t;
   typedef logic [`DEC_IMMW-1:0]   imm_t;
   typedef logic [`DEC_DISPW-1:0]  disp_t;
   typedef logic [2:0]             byte_cnt_t;

   typedef enum logic [2:0] {opnd_none, opnd_reg, opnd_rm, opnd_imm, opnd_stack} operand_t;

   typedef enum logic [2:0] {alu_pass, alu_add, alu_sub, alu_and, alu_or, alu_xor} alu_op_t;

   typedef enum logic [1:0] {stk_none, stk_push, stk_pop} stack_op_t;

   // Same numbering as the x86 segment registers
   typedef enum logic [2:0] {seg_es, seg_cs, seg_ss, seg_ds, seg_fs, seg_gs} seg_t;

   // Microcode entry points
   typedef enum logic [1:0] {useq_none, useq_leave, useq_xchg, useq_int} useq_t;

   typedef struct packed {
      logic [63:0] displace_n_imm;
      // SIB in the high byte, ModRM in the low byte
      logic [15:0] addressing;
      byte_cnt_t   addressing_bytes;
      byte_cnt_t   displacement_bytes;
      byte_cnt_t   immediate_bytes;
      logic [15:0] opcode;
      byte_cnt_t   opcode_bytes;
      logic [23:0] prefix;
      byte_cnt_t   prefix_bytes;
      pc_t         pc;
      logic        branch_taken;
   } s0_bundle_t;

   typedef struct packed {
      logic [2:0] size;          // 1, 2 or 4 bytes
      logic       set_d_flag;
      logic       clear_d_flag;
      operand_t   op0;
      operand_t   op1;
      logic [2:0] op0_reg;
      logic [2:0] op1_reg;
      logic [7:0] modrm;
      logic [7:0] sib;
      imm_t       imm;
      disp_t      disp;
      alu_op_t    alu_op;
      logic [2:0] flag_0;
      logic [2:0] flag_1;
      stack_op_t  stack_op;
      seg_t       seg_override;
      logic       seg_override_valid;
      logic       rep;
      pc_t        pc;
      logic       branch_taken;
      logic       last;
   } uop_t;

endpackage

`default_nettype wire

// ==== src/imm_disp_separate.sv ====
// Displacement sits in the low bytes of displace_n_imm and the immediate follows it
// Each field is sign-extended from its own byte count
// A count of 4 or more takes the full 32 bits
`default_nettype none

module imm_disp_separate import decode_pkg::*; (
   input  logic [63:0] displace_n_imm,
   input  byte_cnt_t   displacement_bytes,
   input  byte_cnt_t   immediate_bytes,
   output imm_t        imm,
   output disp_t       disp
);

   logic [63:0] imm_field;

   function automatic logic [31:0] sext(input logic [31:0] raw, input byte_cnt_t n);
      logic [31:0] v;
      case (n)
         3'd0: v = '0;
         3'd1: v = {{24{raw[7]}}, raw[7:0]};
         3'd2: v = {{16{raw[15]}}, raw[15:0]};
         3'd3: v = {{8{raw[23]}}, raw[23:0]};
         default: v = raw;
      endcase
      return v;
   endfunction

   // Shift out the displacement so the immediate starts at bit 0
   assign imm_field = displace_n_imm >> {displacement_bytes, 3'b000};

   assign disp = disp_t'(sext(displace_n_imm[31:0], displacement_bytes));
   assign imm  = imm_t'(sext(imm_field[31:0], immediate_bytes));

endmodule

`default_nettype wire

// ==== src/prefix_decode.sv ====
// Up to three prefix bytes with the first one in the low byte
// Bytes beyond prefix_bytes are ignored
// Recognizes the segment overrides, 66 and F3 only
`default_nettype none

module prefix_decode import decode_pkg::*; (
   input  logic [23:0] prefix,
   input  byte_cnt_t   prefix_bytes,
   output seg_t        seg_override,
   output logic        seg_override_valid,
   output logic        size_override,
   output logic        rep
);

   logic [23:0] keep;
   logic [23:0] masked;

   always_comb begin
      case (prefix_bytes)
         3'd0: keep = 24'h000000;
         3'd1: keep = 24'h0000ff;
         3'd2: keep = 24'h00ffff;
         default: keep = 24'hffffff;
      endcase
   end

   assign masked = prefix & keep;

   // Scanned in order so the last segment prefix wins
   always_comb begin
      logic [7:0] pb;
      seg_t       code;
      logic       hit;
      seg_override = seg_ds;
      seg_override_valid = 1'b0;
      size_override = 1'b0;
      rep = 1'b0;
      for (int i = 0; i < 3; i++) begin
         pb = masked[8*i +: 8];
         code = seg_ds;
         hit = 1'b1;
         case (pb)
            8'h26: code = seg_es;
            8'h2e: code = seg_cs;
            8'h36: code = seg_ss;
            8'h3e: code = seg_ds;
            8'h64: code = seg_fs;
            8'h65: code = seg_gs;
            default: hit = 1'b0;
         endcase
         if (hit) begin
            seg_override = code;
            seg_override_valid = 1'b1;
         end
         if (pb == 8'h66) begin
            size_override = 1'b1;
         end
         if (pb == 8'hf3) begin
            rep = 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== src/op_and_rm_decode.sv ====
// One-byte opcodes only. 0F escapes, HLT and unlisted opcodes are illegal
// Byte forms (even ALU opcodes, 86) give size 1 and ignore the 66 prefix
// LEAVE and XCHG return a microcode entry and a template uop
`default_nettype none
`include "decode_macros.svh"

module op_and_rm_decode import decode_pkg::*; (
   input  s0_bundle_t s0,
   input  imm_t       imm,
   input  disp_t      disp,
   input  seg_t       seg_override,
   input  logic       seg_override_valid,
   input  logic       size_override,
   input  logic       rep,
   output uop_t       uop,
   output useq_t      entry,
   output logic       illegal,
   output logic [3:0] length
);

   logic [15:0] opcode_m;
   logic [7:0]  opc;
   logic        one_byte;
   logic [2:0]  reg_f;
   logic [2:0]  rm_f;
   logic        alu_form;
   alu_op_t     alu_sel;

   always_comb begin
      case (s0.opcode_bytes)
         3'd0: opcode_m = 16'h0000;
         3'd1: opcode_m = {8'h00, s0.opcode[7:0]};
         default: opcode_m = s0.opcode;
      endcase
   end

   assign opc      = opcode_m[7:0];
   assign one_byte = (s0.opcode_bytes != 3'd0) && (opcode_m[15:8] == 8'h00);
   assign reg_f    = s0.addressing[5:3];
   assign rm_f     = s0.addressing[2:0];

   assign length = {1'b0, s0.prefix_bytes} + {1'b0, s0.opcode_bytes}
                 + {1'b0, s0.addressing_bytes} + {1'b0, s0.displacement_bytes}
                 + {1'b0, s0.immediate_bytes};

   // r/m-reg group, bit 1 is direction and bit 0 is width
   always_comb begin
      alu_form = 1'b1;
      case (opc[7:2])
         6'h00: alu_sel = alu_add;
         6'h02: alu_sel = alu_or;
         6'h08: alu_sel = alu_and;
         6'h0a: alu_sel = alu_sub;
         6'h0c: alu_sel = alu_xor;
         6'h22: alu_sel = alu_pass;
         default: begin
            alu_sel = alu_pass;
            alu_form = 1'b0;
         end
      endcase
   end

   always_comb begin
      uop = '0;
      uop.size = size_override ? 3'd2 : 3'd4;
      uop.modrm = s0.addressing[7:0];
      uop.sib = s0.addressing[15:8];
      uop.imm = imm;
      uop.disp = disp;
      uop.seg_override = seg_override;
      uop.seg_override_valid = seg_override_valid;
      uop.rep = rep;
      uop.pc = s0.pc;
      uop.branch_taken = s0.branch_taken;
      uop.last = 1'b1;
      entry = useq_none;
      illegal = 1'b0;
      if (!one_byte) begin
         illegal = 1'b1;
      end else if (alu_form) begin
         uop.alu_op = alu_sel;
         uop.flag_0 = (alu_sel == alu_pass) ? `DEC_FLG_NONE : `DEC_FLG_ARITH;
         if (!opc[0]) begin
            uop.size = 3'd1;
         end
         uop.op0 = opc[1] ? opnd_reg : opnd_rm;
         uop.op0_reg = opc[1] ? reg_f : rm_f;
         uop.op1 = opc[1] ? opnd_rm : opnd_reg;
         uop.op1_reg = opc[1] ? rm_f : reg_f;
      end else begin
         casez (opc)
            8'hc7: begin
               uop.op0 = opnd_rm;
               uop.op0_reg = rm_f;
               uop.op1 = opnd_imm;
            end
            8'b0101_0???: begin
               uop.op0 = opnd_stack;
               uop.op1 = opnd_reg;
               uop.op1_reg = opc[2:0];
               uop.stack_op = stk_push;
            end
            8'b0101_1???: begin
               uop.op0 = opnd_reg;
               uop.op0_reg = opc[2:0];
               uop.op1 = opnd_stack;
               uop.stack_op = stk_pop;
            end
            8'hfc: begin
               uop.clear_d_flag = 1'b1;
               uop.flag_0 = `DEC_FLG_DIR;
            end
            8'hfd: begin
               uop.set_d_flag = 1'b1;
               uop.flag_0 = `DEC_FLG_DIR;
            end
            8'hc9: entry = useq_leave;
            8'b1000_011?: begin
               entry = useq_xchg;
               if (!opc[0]) begin
                  uop.size = 3'd1;
               end
            end
            default: illegal = 1'b1;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== src/microcode_sequencer.sv ====
// Issues one ROM micro-op per seq_advance until the step marked last
// Size, ModRM, segment, PC and registers come from the template at seq_start
// Interrupt steps ignore the template and use int_pc
`default_nettype none
`include "decode_macros.svh"

module microcode_sequencer import decode_pkg::*; (
   input  logic  clk,
   input  logic  reset,
   input  logic  flush,
   input  logic  seq_start,
   input  useq_t entry,
   input  uop_t  template,
   input  pc_t   int_pc,
   input  logic  seq_advance,
   output uop_t  rom_uop,
   output logic  rom_active
);

   localparam int UAW = $clog2(`DEC_UCODE_DEPTH);

   typedef enum logic {seq_idle, seq_run} seq_state_t;

   seq_state_t     state;
   logic [UAW-1:0] upc;
   logic [UAW-1:0] upc_base;
   uop_t           tmpl_q;
   uop_t           int_base;
   logic [2:0]     rm_f;
   logic [2:0]     reg_f;

   // ROM layout is LEAVE at 0, XCHG at 2, interrupt at 5
   always_comb begin
      case (entry)
         useq_leave: upc_base = UAW'(0);
         useq_xchg:  upc_base = UAW'(2);
         default:    upc_base = UAW'(5);
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset || flush) begin
         state <= seq_idle;
         upc <= '0;
      end else if (seq_start) begin
         state <= seq_run;
         upc <= upc_base;
      end else if (seq_advance) begin
         upc <= upc + 1'b1;
         if (rom_uop.last) begin
            state <= seq_idle;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (seq_start) begin
         tmpl_q <= template;
      end
   end

   assign rom_active = (state == seq_run);
   assign rm_f       = tmpl_q.modrm[2:0];
   assign reg_f      = tmpl_q.modrm[5:3];

   always_comb begin
      int_base = '0;
      int_base.size = 3'd4;
      int_base.pc = int_pc;
      int_base.op0 = opnd_stack;
      int_base.stack_op = stk_push;
   end

   // In XCHG an operand of none names the execute-side scratch register
   always_comb begin
      rom_uop = tmpl_q;
      rom_uop.alu_op = alu_pass;
      rom_uop.flag_0 = `DEC_FLG_NONE;
      rom_uop.flag_1 = `DEC_FLG_NONE;
      rom_uop.stack_op = stk_none;
      rom_uop.last = 1'b0;
      case (upc)
         UAW'(0): begin
            // esp <- ebp
            rom_uop.op0 = opnd_reg;
            rom_uop.op0_reg = 3'd4;
            rom_uop.op1 = opnd_reg;
            rom_uop.op1_reg = 3'd5;
         end
         UAW'(1): begin
            rom_uop.op0 = opnd_reg;
            rom_uop.op0_reg = 3'd5;
            rom_uop.op1 = opnd_stack;
            rom_uop.stack_op = stk_pop;
            rom_uop.last = 1'b1;
         end
         UAW'(2): begin
            rom_uop.op0 = opnd_none;
            rom_uop.op1 = opnd_rm;
            rom_uop.op1_reg = rm_f;
         end
         UAW'(3): begin
            rom_uop.op0 = opnd_rm;
            rom_uop.op0_reg = rm_f;
            rom_uop.op1 = opnd_reg;
            rom_uop.op1_reg = reg_f;
         end
         UAW'(4): begin
            rom_uop.op0 = opnd_reg;
            rom_uop.op0_reg = reg_f;
            rom_uop.op1 = opnd_none;
            rom_uop.last = 1'b1;
         end
         UAW'(5): begin
            // Flags image
            rom_uop = int_base;
            rom_uop.flag_1 = `DEC_FLG_ALL;
         end
         default: begin
            rom_uop = int_base;
            rom_uop.op1 = opnd_imm;
            rom_uop.imm = imm_t'(int_pc);
            rom_uop.last = 1'b1;
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== src/decode_stage_1.sv ====
// Decode stage 1 with valid/ready on both sides and a registered output
// Multi-step instructions and interrupt entry hold s0_ready low until done
// An illegal opcode halts the stage until reset
`default_nettype none

module decode_stage_1 import decode_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  logic       flush,
   input  logic       handle_int,
   output logic       halt,
   input  logic       s0_valid,
   output logic       s0_ready,
   input  s0_bundle_t s0,
   output logic       s1_valid,
   input  logic       s1_ready,
   output uop_t       s1
);

   imm_t       dec_imm;
   disp_t      dec_disp;
   seg_t       pre_seg;
   logic       pre_seg_valid;
   logic       pre_size_override;
   logic       pre_rep;
   uop_t       dec_uop;
   useq_t      dec_entry;
   logic       dec_illegal;
   logic [3:0] dec_length;
   uop_t       rom_uop;
   logic       rom_active;
   logic       pending;
   logic       can_load;
   logic       accept;
   logic       load_dec;
   logic       int_go;
   logic       seq_start;
   useq_t      seq_entry;
   logic       seq_advance;
   pc_t        next_pc;

   imm_disp_separate imm_disp_separate_inst (
      .displace_n_imm     (s0.displace_n_imm),
      .displacement_bytes (s0.displacement_bytes),
      .immediate_bytes    (s0.immediate_bytes),
      .imm                (dec_imm),
      .disp               (dec_disp)
   );

   prefix_decode prefix_decode_inst (
      .prefix             (s0.prefix),
      .prefix_bytes       (s0.prefix_bytes),
      .seg_override       (pre_seg),
      .seg_override_valid (pre_seg_valid),
      .size_override      (pre_size_override),
      .rep                (pre_rep)
   );

   op_and_rm_decode op_and_rm_decode_inst (
      .s0                 (s0),
      .imm                (dec_imm),
      .disp               (dec_disp),
      .seg_override       (pre_seg),
      .seg_override_valid (pre_seg_valid),
      .size_override      (pre_size_override),
      .rep                (pre_rep),
      .uop                (dec_uop),
      .entry              (dec_entry),
      .illegal            (dec_illegal),
      .length             (dec_length)
   );

   microcode_sequencer microcode_sequencer_inst (
      .clk         (clk),
      .reset       (reset),
      .flush       (flush),
      .seq_start   (seq_start),
      .entry       (seq_entry),
      .template    (dec_uop),
      .int_pc      (next_pc),
      .seq_advance (seq_advance),
      .rom_uop     (rom_uop),
      .rom_active  (rom_active)
   );

   // Output register is empty or drains this cycle
   assign can_load = !s1_valid || s1_ready;
   assign s0_ready = can_load && !rom_active && !pending && !halt;
   assign accept   = s0_valid && s0_ready;
   assign load_dec = accept && !dec_illegal && (dec_entry == useq_none);
   assign int_go   = pending && !rom_active && can_load && !halt;

   assign seq_start   = (accept && !dec_illegal && (dec_entry != useq_none)) || int_go;
   assign seq_entry   = int_go ? useq_int : dec_entry;
   assign seq_advance = rom_active && can_load;

   always_ff @(posedge clk) begin
      if (reset || flush) begin
         s1_valid <= 1'b0;
         pending <= 1'b0;
      end else begin
         pending <= (pending && !int_go) || handle_int;
         if (can_load) begin
            s1_valid <= seq_advance || load_dec;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         halt <= 1'b0;
      end else if (accept && dec_illegal) begin
         halt <= 1'b1;
      end
   end

   // Sequencer micro-ops take priority over the decoded one
   always_ff @(posedge clk) begin
      if (seq_advance || load_dec) begin
         s1 <= rom_active ? rom_uop : dec_uop;
      end
      if (accept) begin
         next_pc <= s0.pc + pc_t'(dec_length);
      end
   end

endmodule

`default_nettype wire

// ==== verification/decode_stage_1_props.sv ====
// Handshake and reset properties, bound into decode_stage_1
// A flush may drop a stalled micro-op, so the stall check skips flush cycles
`default_nettype none

module decode_stage_1_props import decode_pkg::*; (
   input logic clk,
   input logic reset,
   input logic flush,
   input logic halt,
   input logic s0_ready,
   input logic s1_valid,
   input logic s1_ready,
   input uop_t s1
);

   // Stalled output holds its micro-op
   assert property (@(posedge clk) disable iff (reset)
      s1_valid && !s1_ready && !flush |=> s1_valid && $stable(s1))
      else $error("s1 changed while stalled");

   // Halt is sticky and lets no new micro-op out
   assert property (@(posedge clk) disable iff (reset)
      halt && !s1_valid |=> halt && !s0_ready && !s1_valid)
      else $error("halt dropped, s0_ready high or a micro-op issued while halted");

   assert property (@(posedge clk) reset |=> !s1_valid && !halt)
      else $error("s1_valid or halt high after reset");

endmodule

bind decode_stage_1 decode_stage_1_props decode_stage_1_props_inst (.*);

`default_nettype wire

// ==== verification/decode_stage_1_tb.sv ====
// Directed testbench for decode_stage_1
// Inputs change on falling edges, outputs are sampled 1-2 units after them
// The illegal opcode test must run last since halt only clears on reset
`default_nettype none
`include "decode_macros.svh"

module decode_stage_1_tb import decode_pkg::*; ();

   localparam int NUM_TESTS = 6;
   localparam int MAX_INSTR = 40;
   localparam int CYCLE_BOUND = 60;
   localparam int WATCHDOG = NUM_TESTS * MAX_INSTR * CYCLE_BOUND * 40;

   logic       clk = 1'b0;
   logic       reset;
   logic       flush;
   logic       handle_int;
   logic       halt;
   logic       s0_valid;
   logic       s0_ready;
   s0_bundle_t s0;
   logic       s1_valid;
   logic       s1_ready;
   uop_t       s1;

   integer seed = 32'hbdcc8556;
   int     errors = 0;
   int     tests_run = 0;
   // 0 always ready, 1 random stalls, 2 never ready
   int     ready_mode = 0;
   uop_t   rx_q[$];

   logic [7:0] alu_opcodes [12] = '{8'h01, 8'h03, 8'h09, 8'h0b, 8'h21, 8'h23,
                                    8'h29, 8'h2b, 8'h31, 8'h33, 8'h89, 8'h8b};
   logic [7:0] prefix_codes [8] = '{8'h26, 8'h2e, 8'h36, 8'h3e, 8'h64, 8'h65, 8'h66, 8'hf3};

   decode_stage_1 decode_stage_1_inst (
      .clk        (clk),
      .reset      (reset),
      .flush      (flush),
      .handle_int (handle_int),
      .halt       (halt),
      .s0_valid   (s0_valid),
      .s0_ready   (s0_ready),
      .s0         (s0),
      .s1_valid   (s1_valid),
      .s1_ready   (s1_ready),
      .s1         (s1)
   );

   always #20 clk = ~clk;

   // Drives s1_ready and records every micro-op that transfers at the next edge
   always @(negedge clk) begin
      logic [31:0] r;
      if (ready_mode == 1) begin
         r = $random(seed);
         s1_ready = r[0] | r[1];
      end else begin
         s1_ready = (ready_mode == 0);
      end
      #1;
      if (s1_valid && s1_ready && !reset) begin
         rx_q.push_back(s1);
      end
   end

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic fail(input string what);
      errors++;
      $display("error at %0t: %s", $time, what);
   endtask

   task automatic finish_test(input string name, input int errs_before);
      tests_run++;
      $display("test %s: %s", name, (errors == errs_before) ? "ok" : "FAILED");
   endtask

   function automatic s0_bundle_t make_instr(input logic [7:0] opc, input logic [7:0] modrm,
                                             input logic has_modrm, input pc_t pc);
      s0_bundle_t b;
      b = '0;
      b.opcode = {8'h00, opc};
      b.opcode_bytes = 3'd1;
      b.addressing = {8'h00, modrm};
      b.addressing_bytes = has_modrm ? 3'd1 : 3'd0;
      b.pc = pc;
      return b;
   endfunction

   // Reference sign extension from a byte count
   function automatic logic [31:0] sext_ref(input logic [63:0] raw, input int nbytes);
      logic [63:0] mask;
      logic [63:0] v;
      if (nbytes == 0) return 32'h0;
      if (nbytes >= 4) return raw[31:0];
      mask = (64'd1 << (8 * nbytes)) - 64'd1;
      v = raw & mask;
      if (v[8 * nbytes - 1]) v = v | ~mask;
      return v[31:0];
   endfunction

   function automatic alu_op_t alu_of(input logic [7:0] opc);
      case (opc)
         8'h01, 8'h03: return alu_add;
         8'h09, 8'h0b: return alu_or;
         8'h21, 8'h23: return alu_and;
         8'h29, 8'h2b: return alu_sub;
         8'h31, 8'h33: return alu_xor;
         default: return alu_pass;
      endcase
   endfunction

   function automatic int seg_of(input logic [7:0] pb);
      case (pb)
         8'h26: return 0;
         8'h2e: return 1;
         8'h36: return 2;
         8'h3e: return 3;
         8'h64: return 4;
         8'h65: return 5;
         default: return -1;
      endcase
   endfunction

   function automatic int pick_len(input logic [1:0] sel);
      case (sel)
         2'd0: return 0;
         2'd1: return 1;
         2'd2: return 2;
         default: return 4;
      endcase
   endfunction

   task automatic send(input s0_bundle_t b);
      int n;
      n = 0;
      @(negedge clk);
      s0 = b;
      s0_valid = 1'b1;
      #2;
      while (!s0_ready && n < CYCLE_BOUND) begin
         @(negedge clk);
         #2;
         n++;
      end
      if (!s0_ready) fail("instruction was not accepted");
      @(negedge clk);
      s0_valid = 1'b0;
   endtask

   task automatic wait_rx(input int target);
      int n;
      n = 0;
      while (rx_q.size() < target && n < CYCLE_BOUND) begin
         @(negedge clk);
         #2;
         n++;
      end
      if (rx_q.size() < target) fail("micro-op did not arrive");
   endtask

   // Also checks that no new instruction is taken while the sequence runs
   task automatic wait_seq(input int target);
      int n;
      n = 0;
      #2;
      while (rx_q.size() < target && n < CYCLE_BOUND) begin
         if (s0_ready) fail("s0_ready high before the last micro-op");
         @(negedge clk);
         #2;
         n++;
      end
      if (rx_q.size() < target) fail("sequence did not complete");
   endtask

   task automatic test_reset_alu();
      int          e0;
      logic [31:0] r;
      logic [7:0]  opc;
      s0_bundle_t  b;
      uop_t        u;
      e0 = errors;
      check("s1_valid", 64'(s1_valid), 64'(0));
      check("halt", 64'(halt), 64'(0));
      for (int i = 0; i < 12; i++) begin
         for (int k = 0; k < 2; k++) begin
            r = $random(seed);
            opc = alu_opcodes[i];
            b = make_instr(opc, {2'b11, r[5:3], r[2:0]}, 1'b1, pc_t'(r));
            if (k == 1) begin
               b.prefix = 24'h000066;
               b.prefix_bytes = 3'd1;
            end
            rx_q.delete();
            send(b);
            wait_rx(1);
            u = rx_q[0];
            check("alu_op", 64'(u.alu_op), 64'(alu_of(opc)));
            check("op0", 64'(u.op0), 64'(opc[1] ? opnd_reg : opnd_rm));
            check("op0_reg", 64'(u.op0_reg), 64'(opc[1] ? r[5:3] : r[2:0]));
            check("op1", 64'(u.op1), 64'(opc[1] ? opnd_rm : opnd_reg));
            check("op1_reg", 64'(u.op1_reg), 64'(opc[1] ? r[2:0] : r[5:3]));
            check("size", 64'(u.size), 64'((k == 1) ? 2 : 4));
         end
      end
      finish_test("reset_alu", e0);
   endtask

   task automatic test_mov_imm();
      int          e0;
      int          dn;
      int          in;
      int          pcount;
      int          exp_seg;
      logic        seg_valid;
      logic        has66;
      logic        hasf3;
      logic [31:0] r;
      logic [31:0] r2;
      logic [31:0] r3;
      logic [63:0] raw;
      logic [7:0]  pre [3];
      s0_bundle_t  b;
      uop_t        u;
      e0 = errors;
      for (int i = 0; i < 16; i++) begin
         r = $random(seed);
         r2 = $random(seed);
         r3 = $random(seed);
         raw = {r2, r3};
         dn = pick_len(r[1:0]);
         in = pick_len(r[3:2]);
         pre[0] = prefix_codes[r[6:4]];
         pre[1] = prefix_codes[r[9:7]];
         pre[2] = prefix_codes[r[12:10]];
         pcount = int'(r[14:13]);
         b = make_instr(8'hc7, {2'b10, 3'b000, r[17:15]}, 1'b1, pc_t'(r2));
         b.displacement_bytes = 3'(dn);
         b.immediate_bytes = 3'(in);
         b.displace_n_imm = raw;
         b.prefix = {pre[2], pre[1], pre[0]};
         b.prefix_bytes = 3'(pcount);
         seg_valid = 1'b0;
         exp_seg = 0;
         has66 = 1'b0;
         hasf3 = 1'b0;
         for (int j = 0; j < pcount; j++) begin
            if (seg_of(pre[j]) >= 0) begin
               seg_valid = 1'b1;
               exp_seg = seg_of(pre[j]);
            end
            if (pre[j] == 8'h66) has66 = 1'b1;
            if (pre[j] == 8'hf3) hasf3 = 1'b1;
         end
         rx_q.delete();
         send(b);
         wait_rx(1);
         u = rx_q[0];
         check("disp", 64'(u.disp), 64'(sext_ref(raw, dn)));
         check("imm", 64'(u.imm), 64'(sext_ref(raw >> (8 * dn), in)));
         check("op1", 64'(u.op1), 64'(opnd_imm));
         check("seg_override_valid", 64'(u.seg_override_valid), 64'(seg_valid));
         if (seg_valid) check("seg_override", 64'(u.seg_override), 64'(exp_seg));
         check("rep", 64'(u.rep), 64'(hasf3));
         check("size", 64'(u.size), 64'(has66 ? 2 : 4));
      end
      finish_test("mov_imm", e0);
   endtask

   task automatic test_stream();
      int          e0;
      logic [31:0] r;
      logic [7:0]  opc;
      s0_bundle_t  b;
      pc_t         exp_pc[$];
      logic        exp_bt[$];
      e0 = errors;
      rx_q.delete();
      ready_mode = 1;
      for (int i = 0; i < 24; i++) begin
         r = $random(seed);
         case (r[1:0])
            2'd0: opc = alu_opcodes[r[7:4] % 4'd12];
            2'd1: opc = {5'b01010, r[6:4]};
            2'd2: opc = {5'b01011, r[6:4]};
            default: opc = r[2] ? 8'hfd : 8'hfc;
         endcase
         b = make_instr(opc, {2'b11, r[13:8]}, r[1:0] == 2'd0, pc_t'($random(seed)));
         b.branch_taken = r[20];
         exp_pc.push_back(b.pc);
         exp_bt.push_back(b.branch_taken);
         send(b);
      end
      wait_rx(24);
      ready_mode = 0;
      for (int i = 0; i < rx_q.size() && i < 24; i++) begin
         check("pc", 64'(rx_q[i].pc), 64'(exp_pc[i]));
         check("branch_taken", 64'(rx_q[i].branch_taken), 64'(exp_bt[i]));
      end
      finish_test("stream", e0);
   endtask

   task automatic test_sequences();
      int          e0;
      logic [31:0] r;
      e0 = errors;
      rx_q.delete();
      send(make_instr(8'hc9, 8'h00, 1'b0, pc_t'(32'h1000)));
      wait_seq(2);
      check("leave0 op0_reg", 64'(rx_q[0].op0_reg), 64'(4));
      check("leave0 op1_reg", 64'(rx_q[0].op1_reg), 64'(5));
      check("leave0 last", 64'(rx_q[0].last), 64'(0));
      check("leave1 op0_reg", 64'(rx_q[1].op0_reg), 64'(5));
      check("leave1 stack_op", 64'(rx_q[1].stack_op), 64'(stk_pop));
      check("leave1 last", 64'(rx_q[1].last), 64'(1));
      r = $random(seed);
      rx_q.delete();
      send(make_instr(8'h87, {2'b11, r[5:0]}, 1'b1, pc_t'(32'h2000)));
      wait_seq(3);
      check("xchg0 op0", 64'(rx_q[0].op0), 64'(opnd_none));
      check("xchg0 op1_reg", 64'(rx_q[0].op1_reg), 64'(r[2:0]));
      check("xchg0 last", 64'(rx_q[0].last), 64'(0));
      check("xchg1 op0_reg", 64'(rx_q[1].op0_reg), 64'(r[2:0]));
      check("xchg1 op1_reg", 64'(rx_q[1].op1_reg), 64'(r[5:3]));
      check("xchg1 last", 64'(rx_q[1].last), 64'(0));
      check("xchg2 op0_reg", 64'(rx_q[2].op0_reg), 64'(r[5:3]));
      check("xchg2 op1", 64'(rx_q[2].op1), 64'(opnd_none));
      check("xchg2 last", 64'(rx_q[2].last), 64'(1));
      finish_test("sequences", e0);
   endtask

   task automatic test_interrupt();
      int         e0;
      int         exp_len;
      s0_bundle_t b;
      e0 = errors;
      b = make_instr(8'hc7, 8'b01_000_011, 1'b1, pc_t'(32'h0040_1230));
      b.displacement_bytes = 3'd1;
      b.immediate_bytes = 3'd4;
      b.prefix = 24'h000066;
      b.prefix_bytes = 3'd1;
      exp_len = 1 + 1 + 1 + 1 + 4;
      rx_q.delete();
      send(b);
      handle_int = 1'b1;
      @(negedge clk);
      handle_int = 1'b0;
      wait_rx(3);
      check("int0 stack_op", 64'(rx_q[1].stack_op), 64'(stk_push));
      check("int0 flag_1", 64'(rx_q[1].flag_1), 64'(`DEC_FLG_ALL));
      check("int0 last", 64'(rx_q[1].last), 64'(0));
      check("int1 stack_op", 64'(rx_q[2].stack_op), 64'(stk_push));
      check("int1 imm", 64'(rx_q[2].imm), 64'(b.pc + 32'(exp_len)));
      check("int1 last", 64'(rx_q[2].last), 64'(1));
      rx_q.delete();
      send(make_instr(8'hfc, 8'h00, 1'b0, pc_t'(32'h3000)));
      send(make_instr(8'hfd, 8'h00, 1'b0, pc_t'(32'h3001)));
      wait_rx(2);
      check("cld clear_d_flag", 64'(rx_q[0].clear_d_flag), 64'(1));
      check("cld set_d_flag", 64'(rx_q[0].set_d_flag), 64'(0));
      check("std set_d_flag", 64'(rx_q[1].set_d_flag), 64'(1));
      check("std clear_d_flag", 64'(rx_q[1].clear_d_flag), 64'(0));
      finish_test("interrupt", e0);
   endtask

   task automatic test_flush_illegal();
      int e0;
      e0 = errors;
      rx_q.delete();
      ready_mode = 2;
      send(make_instr(8'h01, 8'hc1, 1'b1, pc_t'(32'h4000)));
      flush = 1'b1;
      #2;
      check("s1_valid", 64'(s1_valid), 64'(1));
      @(negedge clk);
      flush = 1'b0;
      ready_mode = 0;
      #2;
      check("s1_valid", 64'(s1_valid), 64'(0));
      repeat (3) @(negedge clk);
      #2;
      check("micro-ops after flush", 64'(rx_q.size()), 64'(0));
      send(make_instr(8'hf4, 8'h00, 1'b0, pc_t'(32'h5000)));
      s0 = make_instr(8'h01, 8'hc1, 1'b1, pc_t'(32'h5001));
      s0_valid = 1'b1;
      #2;
      check("halt", 64'(halt), 64'(1));
      repeat (5) begin
         check("s0_ready", 64'(s0_ready), 64'(0));
         @(negedge clk);
         #2;
      end
      @(negedge clk);
      s0_valid = 1'b0;
      check("micro-ops after halt", 64'(rx_q.size()), 64'(0));
      finish_test("flush_illegal", e0);
   endtask

   initial begin
      reset = 1'b1;
      flush = 1'b0;
      handle_int = 1'b0;
      s0_valid = 1'b0;
      s0 = '0;
      s1_ready = 1'b1;
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      test_reset_alu();
      test_mov_imm();
      test_stream();
      test_sequences();
      test_interrupt();
      test_flush_illegal();
      $display("tests run %0d, errors %0d", tests_run, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG);
      $display("timeout: the tests did not finish in time");
      $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+src
src/decode_pkg.sv
src/imm_disp_separate.sv
src/prefix_decode.sv
src/op_and_rm_decode.sv
src/microcode_sequencer.sv
src/decode_stage_1.sv
verification/decode_stage_1_props.sv
verification/decode_stage_1_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the decode stage testbench with Verilator and runs it
cd "$(dirname "$0")" &&
verilator --binary --assert --timing -f all.f --top-module decode_stage_1_tb \
   --Mdir obj_dir -o decode_stage_1_sim &&
./obj_dir/decode_stage_1_sim | tee /dev/stderr | grep -q "Simulation completed successfully" &&
echo "run.sh: PASS" || { echo "run.sh: FAIL"; exit 1; }
